// ==== hw/chess_pkg.sv ====
package chess_pkg;

	localparam int NUM_FILES = 8;

	typedef enum logic [2:0] {
		EMPTY  = 3'd0,
		PAWN   = 3'd1,
		KNIGHT = 3'd2,
		BISHOP = 3'd3,
		ROOK   = 3'd4,
		QUEEN  = 3'd5,
		KING   = 3'd6,
		UNUSED = 3'd7
	} piece_kind_e;

	typedef enum logic {
		WHITE = 1'b0,
		BLACK = 1'b1
	} color_e;

	typedef struct packed {
		color_e      color;
		piece_kind_e kind;
	} square_t;

	typedef square_t [7:0] file_t; // indexed by rank

	// rank-major, square (file f, rank r) sits at bits 32r+4f
	typedef square_t [7:0][7:0] board_t;

	typedef struct packed {
		logic [2:0] file;
		logic [2:0] rank;
	} coord_t;

	localparam square_t WHITE_PAWN = '{color: WHITE, kind: PAWN};
	localparam square_t WHITE_ROOK = '{color: WHITE, kind: ROOK};
	localparam square_t WHITE_KING = '{color: WHITE, kind: KING};

endpackage

// ==== hw/move_pkg.sv ====
package move_pkg;
	import chess_pkg::*;

	localparam int SPECIAL_SLOTS = 4;

	typedef struct packed {
		logic invalid;
		logic promote;
		logic pawn;
		logic pawn_two;
		logic en_passant;
		logic castle;
		logic capture;
	} move_flags_t;

	// 19 bits: [7b flags][6b from][6b to]
	typedef struct packed {
		move_flags_t flags;
		coord_t      from;
		coord_t      to;
	} move_t;

	localparam move_flags_t CASTLE_FLAGS = '{castle: 1'b1, default: 1'b0};
	localparam move_flags_t ENP_FLAGS = '{pawn: 1'b1, en_passant: 1'b1, capture: 1'b1,
		default: 1'b0};
	localparam move_t INVALID_MOVE = '{flags: '{invalid: 1'b1, default: 1'b0},
		from: '0, to: '0};

	typedef enum logic [2:0] {
		S_START,
		S_SPECIAL,
		S_SCAN,
		S_DRAIN,
		S_DONE
	} collect_state_e;

endpackage

// ==== hw/move_fifo.sv ====
`timescale 1ns/1ps
module move_fifo
	import move_pkg::*;
#(
	parameter int DEPTH = 8
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  wr,
	input  move_t wdata,
	input  logic  rden,
	output move_t rdata,
	output logic  empty,
	output logic  full
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	move_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_wr;
	logic do_rd;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign rdata = mem[rd_ptr]; // head word is always visible
	assign do_wr = wr && !full;
	assign do_rd = rden && !empty;

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (reset) wr |-> !full)
		else $error("move_fifo: write while full");
	assert property (@(posedge clk) disable iff (reset) rden |-> !empty)
		else $error("move_fifo: read while empty");

endmodule

// ==== hw/pawn_file_unit.sv ====
`timescale 1ns/1ps
module pawn_file_unit
	import chess_pkg::*;
	import move_pkg::*;
#(
	parameter int DEPTH    = 8,
	parameter int FILE_IDX = 0
) (
	input  logic  clk,
	input  logic  reset,
	input  file_t file_state,
	input  logic  file_rden,
	output move_t file_move,
	output logic  file_empty,
	output logic  file_done
);
	logic [2:0] rank;
	logic [2:0] next_rank;
	logic       push_ok;
	logic       two_ok;
	logic       pend_valid;
	move_t      pend_move;
	move_t      push_move;
	move_t      two_move;
	logic       fifo_wr;
	move_t      fifo_wdata;

	assign next_rank = rank + 3'd1;
	assign push_ok = !file_done && (file_state[rank] == WHITE_PAWN)
		&& (file_state[next_rank].kind == EMPTY);
	// double step only from the home rank, both squares clear
	assign two_ok = push_ok && (rank == 3'd1) && (file_state[3].kind == EMPTY);

	always_comb begin
		push_move = '0;
		push_move.flags.pawn = 1'b1;
		push_move.flags.promote = (next_rank == 3'd7); // last rank
		push_move.from = '{file: 3'(FILE_IDX), rank: rank};
		push_move.to = '{file: 3'(FILE_IDX), rank: next_rank};
		two_move = push_move;
		two_move.flags.pawn_two = 1'b1;
		two_move.to.rank = 3'd3;
	end

	// rank 2 never holds a pawn when a double step was found, so no clash
	assign fifo_wr = pend_valid || push_ok;
	assign fifo_wdata = pend_valid ? pend_move : push_move;

	always_ff @(posedge clk) begin
		if (reset) begin
			rank <= 3'd1;
			file_done <= 1'b0;
			pend_valid <= 1'b0;
		end else begin
			pend_valid <= two_ok;
			if (!file_done) begin
				if (rank == 3'd6)
					file_done <= 1'b1;
				else
					rank <= next_rank;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (two_ok)
			pend_move <= two_move;
	end

	move_fifo #(.DEPTH(DEPTH)) fifo_i (
		.clk(clk),
		.reset(reset),
		.wr(fifo_wr),
		.wdata(fifo_wdata),
		.rden(file_rden),
		.rdata(file_move),
		.empty(file_empty),
		.full()
	);

	assert property (@(posedge clk) disable iff (reset) file_done |=> file_done)
		else $error("pawn_file_unit: file_done fell without reset");

endmodule

// ==== hw/special_moves.sv ====
`timescale 1ns/1ps
module special_moves
	import chess_pkg::*;
	import move_pkg::*;
(
	input  board_t                    board,
	input  logic                      castle_left_ok,
	input  logic                      castle_right_ok,
	input  logic [NUM_FILES-1:0]      enp_flags,
	output move_t [SPECIAL_SLOTS-1:0] special_list
);
	logic       king_home;
	logic       castle_k;
	logic       castle_q;
	logic [2:0] enp_file;
	logic       enp_any;
	logic       enp_left;
	logic       enp_right;

	// squares checked against check or attack are not covered here
	assign king_home = (board[0][4] == WHITE_KING);
	assign castle_k = king_home && (board[0][7] == WHITE_ROOK)
		&& (board[0][5].kind == EMPTY) && (board[0][6].kind == EMPTY) && castle_right_ok;
	assign castle_q = king_home && (board[0][0] == WHITE_ROOK)
		&& (board[0][1].kind == EMPTY) && (board[0][2].kind == EMPTY)
		&& (board[0][3].kind == EMPTY) && castle_left_ok;

	always_comb begin
		enp_file = '0;
		enp_any = 1'b0;
		for (int f = NUM_FILES - 1; f >= 0; f--) begin
			if (enp_flags[f]) begin // lowest flagged file wins
				enp_file = 3'(f);
				enp_any = 1'b1;
			end
		end
	end

	assign enp_left = enp_any && (enp_file != 3'd0)
		&& (board[4][enp_file - 3'd1] == WHITE_PAWN);
	assign enp_right = enp_any && (enp_file != 3'd7)
		&& (board[4][enp_file + 3'd1] == WHITE_PAWN);

	always_comb begin
		for (int s = 0; s < SPECIAL_SLOTS; s++)
			special_list[s] = INVALID_MOVE;
		if (castle_k) begin
			special_list[0].flags = CASTLE_FLAGS;
			special_list[0].from = '{file: 3'd4, rank: 3'd0}; // e1
			special_list[0].to = '{file: 3'd6, rank: 3'd0}; // g1
		end
		if (castle_q) begin
			special_list[1].flags = CASTLE_FLAGS;
			special_list[1].from = '{file: 3'd4, rank: 3'd0};
			special_list[1].to = '{file: 3'd2, rank: 3'd0}; // c1
		end
		if (enp_left) begin
			special_list[2].flags = ENP_FLAGS;
			special_list[2].from = '{file: enp_file - 3'd1, rank: 3'd4};
			special_list[2].to = '{file: enp_file, rank: 3'd5};
		end
		if (enp_right) begin
			special_list[3].flags = ENP_FLAGS;
			special_list[3].from = '{file: enp_file + 3'd1, rank: 3'd4};
			special_list[3].to = '{file: enp_file, rank: 3'd5};
		end
	end

endmodule

// ==== hw/move_collector.sv ====
`timescale 1ns/1ps
module move_collector
	import chess_pkg::*;
	import move_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  move_t [SPECIAL_SLOTS-1:0] special_list,
	input  logic [NUM_FILES-1:0]      file_done,
	input  logic [NUM_FILES-1:0]      file_empty,
	input  move_t [NUM_FILES-1:0]     file_move,
	output logic [NUM_FILES-1:0]      file_rden,
	input  logic                      out_full,
	output logic                      out_wr,
	output move_t                     out_wdata,
	output logic                      done
);
	localparam int SLOT_W = $clog2(SPECIAL_SLOTS);

	collect_state_e       state;
	logic [SLOT_W-1:0]    slot;
	logic [2:0]           cur_file;
	logic [NUM_FILES-1:0] drained;
	logic [NUM_FILES-1:0] ready;
	logic [2:0]           pick;
	logic                 cur_has_move;

	assign ready = file_done & ~drained;
	assign cur_has_move = !file_empty[cur_file];
	assign done = (state == S_DONE);

	always_comb begin
		pick = '0;
		for (int f = NUM_FILES - 1; f >= 0; f--) begin
			if (ready[f])
				pick = 3'(f);
		end
	end

	// writes and pops stall together while the output FIFO is full
	always_comb begin
		out_wr = 1'b0;
		out_wdata = special_list[slot];
		file_rden = '0;
		case (state)
			S_SPECIAL: out_wr = !out_full && !special_list[slot].flags.invalid;
			S_DRAIN: begin
				out_wdata = file_move[cur_file];
				if (cur_has_move && !out_full) begin
					out_wr = 1'b1;
					file_rden[cur_file] = 1'b1;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_START;
			slot <= '0;
			cur_file <= '0;
			drained <= '0;
		end else begin
			case (state)
				S_START: state <= S_SPECIAL;
				S_SPECIAL: begin
					if (!out_full) begin
						slot <= slot + 1'b1;
						if (slot == SLOT_W'(SPECIAL_SLOTS - 1))
							state <= S_SCAN;
					end
				end
				S_SCAN: begin
					if (&drained) begin
						state <= S_DONE;
					end else if (|ready) begin
						cur_file <= pick; // lowest finished file first
						state <= S_DRAIN;
					end
				end
				S_DRAIN: begin
					if (!cur_has_move) begin
						drained[cur_file] <= 1'b1;
						state <= S_SCAN;
					end
				end
				S_DONE: ;
				default: state <= S_START;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) $onehot0(file_rden))
		else $error("move_collector: more than one file FIFO popped");
	assert property (@(posedge clk) disable iff (reset) !(out_wr && out_full))
		else $error("move_collector: write into full output FIFO");

endmodule

// ==== hw/move_gen_top.sv ====
`timescale 1ns/1ps
module move_gen_top
	import chess_pkg::*;
	import move_pkg::*;
#(
	parameter int FILE_FIFO_DEPTH = 8,
	parameter int OUT_FIFO_DEPTH  = 32
) (
	input  logic                 clk,
	input  logic                 reset,
	input  board_t               board,
	input  logic                 castle_left_ok,
	input  logic                 castle_right_ok,
	input  logic [NUM_FILES-1:0] enp_flags,
	input  logic                 out_rden,
	output move_t                out_move,
	output logic                 out_empty,
	output logic                 done
);
	move_t [SPECIAL_SLOTS-1:0] special_list;
	file_t [NUM_FILES-1:0]     file_state;
	logic [NUM_FILES-1:0]      file_done;
	logic [NUM_FILES-1:0]      file_empty;
	logic [NUM_FILES-1:0]      file_rden;
	move_t [NUM_FILES-1:0]     file_move;
	logic                      out_full;
	logic                      out_wr;
	move_t                     out_wdata;

	special_moves special_i (
		.board(board),
		.castle_left_ok(castle_left_ok),
		.castle_right_ok(castle_right_ok),
		.enp_flags(enp_flags),
		.special_list(special_list)
	);

	for (genvar f = 0; f < NUM_FILES; f++) begin : g_file
		for (genvar r = 0; r < 8; r++) begin : g_rank
			assign file_state[f][r] = board[r][f]; // column out of the rank-major board
		end

		pawn_file_unit #(.DEPTH(FILE_FIFO_DEPTH), .FILE_IDX(f)) file_i (
			.clk(clk),
			.reset(reset),
			.file_state(file_state[f]),
			.file_rden(file_rden[f]),
			.file_move(file_move[f]),
			.file_empty(file_empty[f]),
			.file_done(file_done[f])
		);
	end

	move_collector collector_i (
		.clk(clk),
		.reset(reset),
		.special_list(special_list),
		.file_done(file_done),
		.file_empty(file_empty),
		.file_move(file_move),
		.file_rden(file_rden),
		.out_full(out_full),
		.out_wr(out_wr),
		.out_wdata(out_wdata),
		.done(done)
	);

	move_fifo #(.DEPTH(OUT_FIFO_DEPTH)) out_fifo_i (
		.clk(clk),
		.reset(reset),
		.wr(out_wr),
		.wdata(out_wdata),
		.rden(out_rden),
		.rdata(out_move),
		.empty(out_empty),
		.full(out_full)
	);

endmodule

// ==== verification/move_gen_tb.sv ====
`timescale 1ns/1ps
module move_gen_tb
	import chess_pkg::*;
	import move_pkg::*;
();
	localparam int CYCLE_LIMIT = 4000; // 34 boards, each under 100 cycles, plus margin

	logic   clk;
	logic   reset;
	board_t board;
	logic   castle_left_ok;
	logic   castle_right_ok;
	logic [NUM_FILES-1:0] enp_flags;
	logic   out_rden;
	move_t  out_move;
	logic   out_empty;
	logic   done;
	move_t  expected[$];
	integer seed;
	int     cycles = 0;

	move_gen_top #(.FILE_FIFO_DEPTH(8), .OUT_FIFO_DEPTH(32)) dut_i (
		.clk(clk),
		.reset(reset),
		.board(board),
		.castle_left_ok(castle_left_ok),
		.castle_right_ok(castle_right_ok),
		.enp_flags(enp_flags),
		.out_rden(out_rden),
		.out_move(out_move),
		.out_empty(out_empty),
		.done(done)
	);

	task automatic stop_on_error(input string msg);
		$display("ERR %0t: %s", $time, msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$fatal(1);
		end
	end

	assert property (@(posedge clk) disable iff (reset) done |=> done)
		else stop_on_error("done fell before reset");
	assert property (@(posedge clk) disable iff (reset) !out_empty |-> !out_move.flags.invalid)
		else stop_on_error("invalid move at the output");
	assert property (@(posedge clk) reset |=> out_empty && !done)
		else stop_on_error("output FIFO not empty or done high after reset");

	task automatic put(input int f, input int r, input color_e c, input piece_kind_e k);
		board[r][f].color = c;
		board[r][f].kind = k;
	endtask

	task automatic clear_board();
		board = '0;
		enp_flags = '0;
		castle_left_ok = 1'b0;
		castle_right_ok = 1'b0;
	endtask

	function automatic logic is_piece(input int f, input int r, input color_e c,
		input piece_kind_e k);
		return (board[r][f].color == c) && (board[r][f].kind == k);
	endfunction

	function automatic move_t mk(input int ff, input int fr, input int tf, input int tr);
		move_t m;
		m = '0;
		m.from.file = 3'(ff);
		m.from.rank = 3'(fr);
		m.to.file = 3'(tf);
		m.to.rank = 3'(tr);
		return m;
	endfunction

	// expected moves straight from the move rules
	task automatic build_expected();
		move_t m;
		int ep;
		expected.delete();
		for (int f = 0; f < 8; f++) begin
			for (int r = 1; r < 7; r++) begin
				if (is_piece(f, r, WHITE, PAWN) && board[r+1][f].kind == EMPTY) begin
					m = mk(f, r, f, r + 1);
					m.flags.pawn = 1'b1;
					m.flags.promote = (r == 6);
					expected.push_back(m);
					if (r == 1 && board[3][f].kind == EMPTY) begin
						m = mk(f, 1, f, 3);
						m.flags.pawn = 1'b1;
						m.flags.pawn_two = 1'b1;
						expected.push_back(m);
					end
				end
			end
		end
		m = mk(4, 0, 6, 0);
		m.flags.castle = 1'b1;
		if (is_piece(4, 0, WHITE, KING) && is_piece(7, 0, WHITE, ROOK) && castle_right_ok
			&& board[0][5].kind == EMPTY && board[0][6].kind == EMPTY)
			expected.push_back(m);
		m.to.file = 3'd2; // queen side
		if (is_piece(4, 0, WHITE, KING) && is_piece(0, 0, WHITE, ROOK) && castle_left_ok
			&& board[0][1].kind == EMPTY && board[0][2].kind == EMPTY
			&& board[0][3].kind == EMPTY)
			expected.push_back(m);
		ep = -1;
		for (int f = 7; f >= 0; f--)
			if (enp_flags[f])
				ep = f;
		for (int side = -1; side <= 1; side += 2) begin
			if (ep >= 0 && ep + side >= 0 && ep + side < 8
				&& is_piece(ep + side, 4, WHITE, PAWN)) begin
				m = mk(ep + side, 4, ep, 5);
				m.flags.pawn = 1'b1;
				m.flags.en_passant = 1'b1;
				m.flags.capture = 1'b1;
				expected.push_back(m);
			end
		end
	endtask

	task automatic take_move(input move_t m);
		int idx;
		idx = -1;
		foreach (expected[i])
			if (idx < 0 && expected[i] == m)
				idx = i;
		assert (idx >= 0) else stop_on_error($sformatf("unexpected or repeated move %h", m));
		expected.delete(idx);
	endtask

	task automatic run_board(input logic hold);
		logic finished;
		finished = 1'b0;
		build_expected();
		reset = 1'b1;
		out_rden = 1'b0;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
		if (hold) begin
			while (!dut_i.out_full) begin // let the output FIFO fill first
				@(posedge clk);
				#1;
			end
			repeat (4) @(posedge clk);
			#1;
			assert (!done && dut_i.out_full)
				else stop_on_error("collector did not stall on a full output FIFO");
		end
		while (!finished) begin
			@(posedge clk);
			#1;
			out_rden = 1'b0;
			if (!out_empty) begin
				take_move(out_move);
				out_rden = 1'b1;
			end else if (done) begin
				finished = 1'b1;
			end
		end
		assert (expected.size() == 0)
			else stop_on_error($sformatf("%0d expected moves missing", expected.size()));
	endtask

	task automatic random_board();
		logic [31:0] rnd;
		clear_board();
		for (int f = 0; f < 8; f++) begin
			for (int r = 1; r < 8; r++) begin
				rnd = $random(seed);
				case (rnd[2:0])
					3'd0, 3'd1, 3'd2: if (r < 7) put(f, r, WHITE, PAWN);
					3'd3: put(f, r, BLACK, PAWN);
					3'd4: put(f, r, BLACK, KNIGHT);
					default: ;
				endcase
			end
		end
		rnd = $random(seed);
		if (rnd[0]) put(4, 0, WHITE, KING);
		if (rnd[1]) put(0, 0, WHITE, ROOK);
		if (rnd[2]) put(7, 0, WHITE, ROOK);
		if (rnd[3]) put(int'(rnd[6:4]), 0, WHITE, KNIGHT); // may block a castle path
		castle_left_ok = rnd[7];
		castle_right_ok = rnd[8];
		enp_flags = rnd[23:16] & rnd[31:24];
	endtask

	initial begin
		seed = 32'hd2bc_6983;
		reset = 1'b1;
		out_rden = 1'b0;
		clear_board();
		// single pushes, some blocked
		put(0, 2, WHITE, PAWN);
		put(1, 3, WHITE, PAWN);
		put(1, 4, BLACK, KNIGHT);
		put(2, 4, WHITE, PAWN);
		put(3, 5, WHITE, PAWN);
		put(3, 6, WHITE, BISHOP);
		put(5, 2, WHITE, PAWN);
		put(5, 3, WHITE, PAWN);
		run_board(1'b0);
		// double steps and promotion
		clear_board();
		put(0, 1, WHITE, PAWN);
		put(1, 1, WHITE, PAWN);
		put(1, 3, BLACK, PAWN);
		put(2, 1, WHITE, PAWN);
		put(2, 2, BLACK, ROOK);
		put(4, 6, WHITE, PAWN);
		put(7, 6, WHITE, PAWN);
		put(7, 7, BLACK, QUEEN);
		run_board(1'b0);
		for (int v = 0; v < 7; v++) begin
			clear_board();
			put(4, 0, WHITE, KING);
			put(0, 0, WHITE, ROOK);
			put(7, 0, WHITE, ROOK);
			castle_left_ok = 1'b1;
			castle_right_ok = 1'b1;
			case (v)
				1: castle_right_ok = 1'b0;
				2: castle_left_ok = 1'b0;
				3: put(6, 0, WHITE, KNIGHT);
				4: put(1, 0, WHITE, KNIGHT);
				5: put(0, 0, BLACK, ROOK);
				6: put(4, 0, WHITE, QUEEN);
				default: ;
			endcase
			run_board(1'b0);
		end
		for (int v = 0; v < 4; v++) begin
			clear_board();
			put(2, 4, WHITE, PAWN);
			put(4, 4, WHITE, PAWN);
			put(6, 4, WHITE, PAWN);
			put(1, 4, WHITE, PAWN);
			case (v)
				0: enp_flags = 8'b0010_1000; // file 3 wins over file 5
				1: enp_flags = 8'h00;
				2: enp_flags = 8'h01;
				default: enp_flags = 8'h80;
			endcase
			if (v >= 2) begin // pawns where a wrapped neighbour index would land
				put(0, 4, WHITE, PAWN);
				put(7, 4, WHITE, PAWN);
			end
			run_board(1'b0);
		end
		// 36 moves against a 32 deep output FIFO
		clear_board();
		for (int f = 0; f < 8; f++) begin
			put(f, 1, WHITE, PAWN);
			put(f, 4, WHITE, PAWN);
			put(f, 6, WHITE, PAWN);
		end
		put(4, 0, WHITE, KING);
		put(0, 0, WHITE, ROOK);
		put(7, 0, WHITE, ROOK);
		castle_left_ok = 1'b1;
		castle_right_ok = 1'b1;
		enp_flags = 8'h08;
		run_board(1'b1);
		repeat (20) begin
			random_board();
			run_board(1'b0);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== files.f ====
hw/chess_pkg.sv
hw/move_pkg.sv
hw/move_fifo.sv
hw/pawn_file_unit.sv
hw/special_moves.sv
hw/move_collector.sv
hw/move_gen_top.sv
verification/move_gen_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module move_gen_tb -o move_gen_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/move_gen_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1
